// ==== build.f ====
logic/cacheGeomPkg.sv
logic/memBusPkg.sv
logic/cacheCtrl.sv
logic/tagStore.sv
logic/dataStore.sv
logic/refillBuffer.sv
logic/dataCache.sv
verification/tbClock.sv
verification/memModel.sv
verification/dataCacheTb.sv

// ==== logic/cacheCtrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module cacheCtrl (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          reqValid_i,
  input  wire memBusPkg::cpuReq_t      req_i,
  output logic                         ready_o,
  output logic                         rspValid_o,
  output cacheGeomPkg::word_t          rspData_o,
  input  wire                          hit_i,
  input  wire cacheGeomPkg::way_t      hitWay_i,
  input  wire cacheGeomPkg::way_t      victimWay_i,
  input  wire                          victimDirty_i,
  input  wire cacheGeomPkg::tag_t      victimTag_i,
  input  wire cacheGeomPkg::line_t     way0Line_i,
  input  wire cacheGeomPkg::line_t     way1Line_i,
  input  wire cacheGeomPkg::line_t     refillLine_i,
  output cacheGeomPkg::index_t         lookupIndex_o,
  output logic                         readEn_o,
  output memBusPkg::arrayWrite_t       arrayWr_o,
  output logic                         tagWr_o,
  output logic                         missCycle_o,
  output logic                         refillActive_o,
  output logic                         rdReqValid_o,
  output cacheGeomPkg::addr_t          rdReqAddr_o,
  input  wire                          rdReqReady_i,
  output logic                         wbValid_o,
  output memBusPkg::wbReq_t            wb_o,
  input  wire                          wbReady_i,
  input  wire                          beatLast_i
);

  typedef enum logic [2:0] {
    idle,
    compare,
    writeBack,
    refillReq,
    refillData,
    fill,
    reread
  } state_t;

  state_t                    state;
  state_t                    stateNext;
  memBusPkg::cpuReq_t        reqQ;
  cacheGeomPkg::addrFields_t reqAddr;
  cacheGeomPkg::addrFields_t newAddr;
  cacheGeomPkg::line_t       hitLine;
  cacheGeomPkg::word_t       hitWord;
  cacheGeomPkg::word_t       storeWord;
  cacheGeomPkg::byteMask_t   storeMask;
  cacheGeomPkg::line_t       storeLine;
  cacheGeomPkg::lineMask_t   storeLineMask;
  logic                      accept;
  logic                      storeHit;

  assign reqAddr  = reqQ.addr;
  assign newAddr  = req_i.addr;
  assign accept   = (state == idle) && reqValid_i;
  assign storeHit = (state == compare) && hit_i && reqQ.write;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      idle:       if (reqValid_i) stateNext = compare;
      compare: begin
        if (hit_i) begin
          stateNext = idle;
        end else if (victimDirty_i) begin
          stateNext = writeBack;
        end else begin
          stateNext = refillReq;
        end
      end
      writeBack:  if (wbReady_i) stateNext = refillReq;
      refillReq:  if (rdReqReady_i) stateNext = refillData;
      refillData: if (beatLast_i) stateNext = fill;
      // line is in the array now, read it back and compare again
      fill:       stateNext = reread;
      reread:     stateNext = compare;
      default:    stateNext = idle;
    endcase
  end

  // request held from acceptance until the response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqQ <= '0;
    end else if (accept) begin
      reqQ <= req_i;
    end
  end

  assign ready_o = (state == idle);

  // arrays are read in the accept cycle so compare sees the lines
  assign readEn_o      = accept || (state == reread);
  assign lookupIndex_o = (state == idle) ? newAddr.index : reqAddr.index;

  // load data from the hitting way
  assign hitLine = hitWay_i ? way1Line_i : way0Line_i;
  assign hitWord = hitLine[reqAddr.wordSel*cacheGeomPkg::WordBits +: cacheGeomPkg::WordBits];

  assign rspValid_o = (state == compare) && hit_i;
  assign rspData_o  = (rspValid_o && !reqQ.write) ? hitWord : '0;

  // align store bytes to the byte offset, then place them in the line
  always_comb begin
    storeWord     = reqQ.data << {reqAddr.byteSel, 3'b000};
    storeMask     = reqQ.mask << reqAddr.byteSel;
    storeLine     = '0;
    storeLineMask = '0;
    storeLine[reqAddr.wordSel*cacheGeomPkg::WordBits +: cacheGeomPkg::WordBits] = storeWord;
    storeLineMask[reqAddr.wordSel*cacheGeomPkg::WordBytes +: cacheGeomPkg::WordBytes] =
      storeMask;
  end

  always_comb begin
    arrayWr_o       = '0;
    arrayWr_o.index = reqAddr.index;
    if (state == fill) begin
      arrayWr_o.we   = 1'b1;
      arrayWr_o.way  = victimWay_i;
      arrayWr_o.data = refillLine_i;
      arrayWr_o.mask = '1;
    end else if (storeHit) begin
      arrayWr_o.we   = 1'b1;
      arrayWr_o.way  = hitWay_i;
      arrayWr_o.data = storeLine;
      arrayWr_o.mask = storeLineMask;
    end
  end

  assign tagWr_o        = (state == fill);
  assign missCycle_o    = (state == compare) && !hit_i;
  assign refillActive_o = (state == refillData);

  // refill from the request tag
  assign rdReqValid_o = (state == refillReq);
  assign rdReqAddr_o  = {reqAddr.tag, reqAddr.index, {cacheGeomPkg::OffsetBits{1'b0}}};

  // victim line still sits in the read registers from the accept cycle
  assign wbValid_o = (state == writeBack);
  assign wb_o.addr = {victimTag_i, reqAddr.index, {cacheGeomPkg::OffsetBits{1'b0}}};
  assign wb_o.line = victimWay_i ? way1Line_i : way0Line_i;

endmodule

`default_nettype wire

// ==== logic/cacheGeomPkg.sv ====
`default_nettype none

package cacheGeomPkg;

  // cache organization
  localparam int NumWays      = 2;
  localparam int NumSets      = 64;
  localparam int BeatsPerLine = 4;

  localparam int AddrBits   = 32;
  localparam int WordBits   = 64;
  localparam int WordBytes  = WordBits / 8;
  localparam int LineBytes  = BeatsPerLine * WordBytes;
  localparam int OffsetBits = $clog2(LineBytes);
  localparam int IndexBits  = $clog2(NumSets);
  localparam int TagBits    = AddrBits - IndexBits - OffsetBits;

  typedef logic [AddrBits-1:0]                 addr_t;
  typedef logic [TagBits-1:0]                  tag_t;
  typedef logic [IndexBits-1:0]                index_t;
  typedef logic [$clog2(BeatsPerLine)-1:0]     wordSel_t;
  typedef logic [$clog2(WordBytes)-1:0]        byteSel_t;
  typedef logic [WordBits-1:0]                 word_t;
  typedef logic [WordBytes-1:0]                byteMask_t;
  typedef logic [BeatsPerLine*WordBits-1:0]    line_t;
  typedef logic [LineBytes-1:0]                lineMask_t;
  typedef logic [$clog2(NumWays)-1:0]          way_t;

  // byte address split into its lookup fields, msb first
  typedef struct packed {
    tag_t     tag;
    index_t   index;
    wordSel_t wordSel;
    byteSel_t byteSel;
  } addrFields_t;

endpackage

`default_nettype wire

// ==== logic/dataCache.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataCache (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          reqValid_i,
  input  wire memBusPkg::cpuReq_t      req_i,
  output logic                         ready_o,
  output logic                         rspValid_o,
  output cacheGeomPkg::word_t          rspData_o,
  output logic                         rdReqValid_o,
  output cacheGeomPkg::addr_t          rdReqAddr_o,
  input  wire                          rdReqReady_i,
  input  wire                          beatValid_i,
  input  wire                          beatLast_i,
  input  wire cacheGeomPkg::word_t     beatData_i,
  output logic                         wbValid_o,
  output memBusPkg::wbReq_t            wb_o,
  input  wire                          wbReady_i
);

  logic                      hit;
  cacheGeomPkg::way_t        hitWay;
  cacheGeomPkg::way_t        victimWay;
  logic                      victimDirty;
  cacheGeomPkg::tag_t        victimTag;
  cacheGeomPkg::line_t       way0Line;
  cacheGeomPkg::line_t       way1Line;
  cacheGeomPkg::line_t       refillLine;
  cacheGeomPkg::index_t      lookupIndex;
  logic                      readEn;
  memBusPkg::arrayWrite_t    arrayWr;
  logic                      tagWr;
  logic                      missCycle;
  logic                      refillActive;

  cacheCtrl u_cacheCtrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (reqValid_i),
    .req_i          (req_i),
    .ready_o        (ready_o),
    .rspValid_o     (rspValid_o),
    .rspData_o      (rspData_o),
    .hit_i          (hit),
    .hitWay_i       (hitWay),
    .victimWay_i    (victimWay),
    .victimDirty_i  (victimDirty),
    .victimTag_i    (victimTag),
    .way0Line_i     (way0Line),
    .way1Line_i     (way1Line),
    .refillLine_i   (refillLine),
    .lookupIndex_o  (lookupIndex),
    .readEn_o       (readEn),
    .arrayWr_o      (arrayWr),
    .tagWr_o        (tagWr),
    .missCycle_o    (missCycle),
    .refillActive_o (refillActive),
    .rdReqValid_o   (rdReqValid_o),
    .rdReqAddr_o    (rdReqAddr_o),
    .rdReqReady_i   (rdReqReady_i),
    .wbValid_o      (wbValid_o),
    .wb_o           (wb_o),
    .wbReady_i      (wbReady_i),
    .beatLast_i     (beatLast_i)
  );

  // the refill address always carries the latched request tag
  tagStore u_tagStore (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookupIndex_i (lookupIndex),
    .lookupTag_i   (rdReqAddr_o[cacheGeomPkg::AddrBits-1 -: cacheGeomPkg::TagBits]),
    .tagWr_i       (tagWr),
    .arrayWr_i     (arrayWr),
    .missCycle_i   (missCycle),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  dataStore u_dataStore (
    .clk         (clk),
    .readEn_i    (readEn),
    .readIndex_i (lookupIndex),
    .arrayWr_i   (arrayWr),
    .way0Line_o  (way0Line),
    .way1Line_o  (way1Line)
  );

  refillBuffer u_refillBuffer (
    .clk         (clk),
    .rst_n       (rst_n),
    .active_i    (refillActive),
    .beatValid_i (beatValid_i),
    .beatLast_i  (beatLast_i),
    .beatData_i  (beatData_i),
    .line_o      (refillLine)
  );

endmodule

`default_nettype wire

// ==== logic/dataStore.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataStore (
  input  wire                          clk,
  input  wire                          readEn_i,
  input  wire cacheGeomPkg::index_t    readIndex_i,
  input  wire memBusPkg::arrayWrite_t  arrayWr_i,
  output cacheGeomPkg::line_t          way0Line_o,
  output cacheGeomPkg::line_t          way1Line_o
);

  cacheGeomPkg::line_t mem [cacheGeomPkg::NumWays][cacheGeomPkg::NumSets];

  // byte lanes of the selected way only
  always_ff @(posedge clk) begin
    if (arrayWr_i.we) begin
      for (int b = 0; b < cacheGeomPkg::LineBytes; b++) begin
        if (arrayWr_i.mask[b]) begin
          mem[arrayWr_i.way][arrayWr_i.index][b*8 +: 8] <= arrayWr_i.data[b*8 +: 8];
        end
      end
    end
  end

  // both ways read together, held until the next strobe
  always_ff @(posedge clk) begin
    if (readEn_i) begin
      way0Line_o <= mem[0][readIndex_i];
      way1Line_o <= mem[1][readIndex_i];
    end
  end

endmodule

`default_nettype wire

// ==== logic/memBusPkg.sv ====
`default_nettype none

package memBusPkg;

  // one load or store from the pipeline
  typedef struct packed {
    logic                    write;
    cacheGeomPkg::addr_t     addr;
    cacheGeomPkg::word_t     data;
    cacheGeomPkg::byteMask_t mask;
  } cpuReq_t;

  // dirty victim going back to memory, addr is line aligned
  typedef struct packed {
    cacheGeomPkg::addr_t addr;
    cacheGeomPkg::line_t line;
  } wbReq_t;

  // write command shared by tag store and data store
  // a fill carries a full mask, a store hit only its own bytes
  typedef struct packed {
    logic                    we;
    cacheGeomPkg::way_t      way;
    cacheGeomPkg::index_t    index;
    cacheGeomPkg::line_t     data;
    cacheGeomPkg::lineMask_t mask;
  } arrayWrite_t;

endpackage

`default_nettype wire

// ==== logic/refillBuffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module refillBuffer (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          active_i,
  input  wire                          beatValid_i,
  input  wire                          beatLast_i,
  input  wire cacheGeomPkg::word_t     beatData_i,
  output cacheGeomPkg::line_t          line_o
);

  cacheGeomPkg::wordSel_t beatCnt;
  logic                   beatTake;

  assign beatTake = active_i && beatValid_i;

  // slot of the next beat, lowest word arrives first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (beatTake) begin
      beatCnt <= beatLast_i ? '0 : beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (beatTake) begin
      line_o[beatCnt*cacheGeomPkg::WordBits +: cacheGeomPkg::WordBits] <= beatData_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/tagStore.sv ====
`timescale 1ns/10ps
`default_nettype none

module tagStore (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire cacheGeomPkg::index_t    lookupIndex_i,
  input  wire cacheGeomPkg::tag_t      lookupTag_i,
  input  wire                          tagWr_i,
  input  wire memBusPkg::arrayWrite_t  arrayWr_i,
  input  wire                          missCycle_i,
  output logic                         hit_o,
  output cacheGeomPkg::way_t           hitWay_o,
  output cacheGeomPkg::way_t           victimWay_o,
  output logic                         victimDirty_o,
  output cacheGeomPkg::tag_t           victimTag_o
);

  logic [cacheGeomPkg::NumSets-1:0] validQ [cacheGeomPkg::NumWays];
  logic [cacheGeomPkg::NumSets-1:0] dirtyQ [cacheGeomPkg::NumWays];
  cacheGeomPkg::tag_t               tagMem [cacheGeomPkg::NumWays][cacheGeomPkg::NumSets];
  logic [cacheGeomPkg::NumWays-1:0] wayHit;
  cacheGeomPkg::way_t               victimBit;
  cacheGeomPkg::way_t               replWay;

  // compare both ways against the lookup tag
  always_comb begin
    hitWay_o = '0;
    for (int w = 0; w < cacheGeomPkg::NumWays; w++) begin
      wayHit[w] = validQ[w][lookupIndex_i] && (tagMem[w][lookupIndex_i] == lookupTag_i);
      if (wayHit[w]) begin
        hitWay_o = cacheGeomPkg::way_t'(w);
      end
    end
    hit_o = |wayHit;
  end

  // the toggle bit picks the victim in the miss cycle,
  // later states use the way captured at that point
  assign victimWay_o   = missCycle_i ? victimBit : replWay;
  assign victimDirty_o = dirtyQ[victimWay_o][lookupIndex_i];
  assign victimTag_o   = tagMem[victimWay_o][lookupIndex_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < cacheGeomPkg::NumWays; w++) begin
        validQ[w] <= '0;
        dirtyQ[w] <= '0;
      end
      victimBit <= '0;
      replWay   <= '0;
    end else begin
      if (arrayWr_i.we) begin
        if (tagWr_i) begin
          // fill brings in a clean line
          validQ[arrayWr_i.way][arrayWr_i.index] <= 1'b1;
          dirtyQ[arrayWr_i.way][arrayWr_i.index] <= 1'b0;
        end else begin
          dirtyQ[arrayWr_i.way][arrayWr_i.index] <= 1'b1;
        end
      end
      if (missCycle_i) begin
        replWay   <= victimBit;
        victimBit <= ~victimBit;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (arrayWr_i.we && tagWr_i) begin
      tagMem[arrayWr_i.way][arrayWr_i.index] <= lookupTag_i;
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the data cache regression, verdict taken from the simulation log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module dataCacheTb -f build.f \
  -o dataCacheSim > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/dataCacheSim > sim.log 2>&1 || echo "simulator exited with nonzero status"
cat sim.log

grep -q "Regression failed" sim.log && { echo "FAIL: see sim.log"; exit 1; }
grep -q "Regression passed" sim.log || { echo "FAIL: no verdict in sim.log"; exit 1; }
echo "PASS"
exit 0

// ==== verification/dataCacheTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module dataCacheTb;

  localparam int          ClkPeriod   = 100;
  localparam int          DriveDelay  = 10;
  localparam int          ResetCycles = 8;
  localparam int          RandomOps   = 200;
  localparam int          RandTagBase = 'h155;
  localparam logic [31:0] RandSeed    = 32'hb6cf81ae;
  // about 210 requests and a dirty miss costs under 25 cycles
  localparam int          MaxCycles   = 20000;
  localparam cacheGeomPkg::word_t PatternKey = 64'h5ac3_96e1_0f78_d2b4;

  logic                    clk;
  logic                    rst_n;
  logic                    reqValid;
  memBusPkg::cpuReq_t      cpuReq;
  logic                    ready;
  logic                    rspValid;
  cacheGeomPkg::word_t     rspData;
  logic                    rdReqValid;
  cacheGeomPkg::addr_t     rdReqAddr;
  logic                    rdReqReady;
  logic                    beatValid;
  logic                    beatLast;
  cacheGeomPkg::word_t     beatData;
  logic                    wbValid;
  memBusPkg::wbReq_t       wb;
  logic                    wbReady;
  int                      rdCount;
  cacheGeomPkg::addr_t     lastRdAddr;
  int                      wbCount;
  cacheGeomPkg::addr_t     lastWbAddr;
  cacheGeomPkg::line_t     lastWbLine;
  int                      cycleCount = 0;
  // architectural view of memory keyed by word address
  cacheGeomPkg::word_t     shadow [cacheGeomPkg::addr_t];

  tbClock #(.PeriodNs(ClkPeriod)) u_tbClock (.clk_o(clk));

  dataCache u_dataCache (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqValid_i   (reqValid),
    .req_i        (cpuReq),
    .ready_o      (ready),
    .rspValid_o   (rspValid),
    .rspData_o    (rspData),
    .rdReqValid_o (rdReqValid),
    .rdReqAddr_o  (rdReqAddr),
    .rdReqReady_i (rdReqReady),
    .beatValid_i  (beatValid),
    .beatLast_i   (beatLast),
    .beatData_i   (beatData),
    .wbValid_o    (wbValid),
    .wb_o         (wb),
    .wbReady_i    (wbReady)
  );

  memModel #(.PatternKey(PatternKey), .DriveDelay(DriveDelay)) u_memModel (
    .clk          (clk),
    .rst_n        (rst_n),
    .rdReqValid_i (rdReqValid),
    .rdReqAddr_i  (rdReqAddr),
    .rdReqReady_o (rdReqReady),
    .beatValid_o  (beatValid),
    .beatLast_o   (beatLast),
    .beatData_o   (beatData),
    .wbValid_i    (wbValid),
    .wb_i         (wb),
    .wbReady_o    (wbReady),
    .rdCount_o    (rdCount),
    .lastRdAddr_o (lastRdAddr),
    .wbCount_o    (wbCount),
    .lastWbAddr_o (lastWbAddr),
    .lastWbLine_o (lastWbLine)
  );

  function automatic cacheGeomPkg::addr_t wordAddr(input cacheGeomPkg::addr_t a);
    return {a[31:3], 3'b000};
  endfunction

  function automatic cacheGeomPkg::word_t shadowRead(input cacheGeomPkg::addr_t a);
    if (shadow.exists(wordAddr(a))) return shadow[wordAddr(a)];
    return cacheGeomPkg::word_t'(wordAddr(a)) ^ PatternKey;
  endfunction

  // data and mask move up by the byte offset and bytes past the word are lost
  function automatic cacheGeomPkg::word_t mergeStore(input cacheGeomPkg::word_t old,
      input int off, input cacheGeomPkg::word_t data, input cacheGeomPkg::byteMask_t mask);
    cacheGeomPkg::word_t res;
    res = old;
    for (int k = off; k < 8; k++) begin
      if (mask[k-off]) res[k*8 +: 8] = data[(k-off)*8 +: 8];
    end
    return res;
  endfunction

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkWord(input string name, input cacheGeomPkg::word_t exp,
                           input cacheGeomPkg::word_t act);
    if (act !== exp) abortRun($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic checkAddr(input string name, input cacheGeomPkg::addr_t exp,
                           input cacheGeomPkg::addr_t act);
    if (act !== exp) abortRun($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic checkLine(input string name, input cacheGeomPkg::line_t exp,
                           input cacheGeomPkg::line_t act);
    if (act !== exp) abortRun($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
  endtask

  // one request with its latency counted in cycles from acceptance to response
  task automatic access(input logic write, input cacheGeomPkg::addr_t addr,
                        input cacheGeomPkg::word_t data, input cacheGeomPkg::byteMask_t mask,
                        output cacheGeomPkg::word_t rsp, output int latency);
    @(posedge clk);
    #DriveDelay;
    while (!ready) begin
      @(posedge clk);
      #DriveDelay;
    end
    reqValid     = 1'b1;
    cpuReq.write = write;
    cpuReq.addr  = addr;
    cpuReq.data  = data;
    cpuReq.mask  = mask;
    @(posedge clk);
    #DriveDelay;
    reqValid = 1'b0;
    latency  = 1;
    while (!rspValid) begin
      @(posedge clk);
      #DriveDelay;
      latency++;
    end
    rsp = rspData;
  endtask

  task automatic loadCheck(input string name, input cacheGeomPkg::addr_t addr,
                           output int latency);
    cacheGeomPkg::word_t rsp;
    access(1'b0, addr, '0, '0, rsp, latency);
    checkWord(name, shadowRead(addr), rsp);
  endtask

  task automatic storeCheck(input string name, input cacheGeomPkg::addr_t addr,
                            input cacheGeomPkg::word_t data,
                            input cacheGeomPkg::byteMask_t mask, output int latency);
    cacheGeomPkg::word_t       rsp;
    cacheGeomPkg::addrFields_t f;
    access(1'b1, addr, data, mask, rsp, latency);
    checkWord(name, '0, rsp);
    f = addr;
    shadow[wordAddr(addr)] = mergeStore(shadowRead(addr), int'(f.byteSel), data, mask);
  endtask

  task automatic resetLevels();
    if (ready !== 1'b1) abortRun("ready_o is not high after reset");
    if (rspValid !== 1'b0) abortRun("rspValid_o is not low after reset");
    if (rdReqValid !== 1'b0) abortRun("rdReqValid_o is not low after reset");
    if (wbValid !== 1'b0) abortRun("wbValid_o is not low after reset");
  endtask

  task automatic missThenHit();
    cacheGeomPkg::addr_t base;
    int                  rdBefore;
    int                  lat;
    base     = 32'h0001_2040;
    rdBefore = rdCount;
    loadCheck("missLoad", base + 32'h8, lat);
    if (rdCount != rdBefore + 1) abortRun("cold load did not issue exactly one refill");
    checkAddr("missRefillAddr", base, lastRdAddr);
    rdBefore = rdCount;
    loadCheck("hitLoad", base + 32'h18, lat);
    if (rdCount != rdBefore) abortRun("load to a cached line issued a refill");
    if (lat != 1) abortRun($sformatf("load hit answered after %0d cycles, not 1", lat));
  endtask

  task automatic maskedStoreHit();
    cacheGeomPkg::addr_t base;
    int                  lat;
    base = 32'h0001_2040;
    // offset 3 pushes the two upper mask bits out of the word
    storeCheck("storeHit", base + 32'h13, 64'h8877_6655_4433_2211, 8'hc5, lat);
    if (lat != 1) abortRun($sformatf("store hit answered after %0d cycles, not 1", lat));
    loadCheck("loadAfterStore", base + 32'h10, lat);
  endtask

  task automatic dirtyEviction();
    cacheGeomPkg::addr_t first;
    cacheGeomPkg::addr_t second;
    cacheGeomPkg::addr_t third;
    cacheGeomPkg::line_t expLine;
    int                  wbBefore;
    int                  lat;
    first  = 32'h0004_00a0;
    second = first + 32'h800;
    third  = first + 32'h1000;
    loadCheck("evFirstLoad", first, lat);
    storeCheck("evFirstStore", first + 32'h8, 64'hdead_beef_cafe_f00d, 8'h3c, lat);
    wbBefore = wbCount;
    loadCheck("evSecondLoad", second + 32'h10, lat);
    if (wbCount != wbBefore) abortRun("fill into the free way wrote a line back");
    for (int w = 0; w < cacheGeomPkg::BeatsPerLine; w++) begin
      expLine[w*64 +: 64] = shadowRead(cacheGeomPkg::addr_t'(first + 8 * w));
    end
    // toggle lands on the way holding the dirty first line
    loadCheck("evThirdLoad", third, lat);
    if (wbCount != wbBefore + 1) abortRun("eviction of the dirty line gave no write-back");
    checkAddr("evWbAddr", first, lastWbAddr);
    checkLine("evWbLine", expLine, lastWbLine);
    loadCheck("evReload", first + 32'h8, lat);
  endtask

  task automatic randomTraffic();
    cacheGeomPkg::addrFields_t f;
    cacheGeomPkg::word_t       data;
    cacheGeomPkg::byteMask_t   mask;
    int                        lat;
    for (int n = 0; n < RandomOps; n++) begin
      f.tag     = cacheGeomPkg::tag_t'(RandTagBase + $urandom_range(2));
      f.index   = cacheGeomPkg::index_t'(8 + $urandom_range(7));
      f.wordSel = cacheGeomPkg::wordSel_t'($urandom);
      f.byteSel = cacheGeomPkg::byteSel_t'($urandom);
      if ($urandom_range(1) == 1) begin
        data = {$urandom, $urandom};
        mask = cacheGeomPkg::byteMask_t'($urandom);
        storeCheck($sformatf("randStore%0d", n), f, data, mask, lat);
      end else begin
        loadCheck($sformatf("randLoad%0d", n), f, lat);
      end
    end
  endtask

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > MaxCycles) abortRun($sformatf("run did not end in %0d cycles", MaxCycles));
  end

  initial begin
    void'($urandom(RandSeed));
    rst_n    = 1'b0;
    reqValid = 1'b0;
    cpuReq   = '0;
    repeat (ResetCycles) @(posedge clk);
    #DriveDelay;
    rst_n = 1'b1;
    resetLevels();
    missThenHit();
    maskedStoreHit();
    dirtyEviction();
    randomTraffic();
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/memModel.sv ====
`timescale 1ns/10ps
`default_nettype none

module memModel #(
  parameter cacheGeomPkg::word_t PatternKey = 64'h0,
  parameter int                  DriveDelay = 10
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          rdReqValid_i,
  input  wire cacheGeomPkg::addr_t     rdReqAddr_i,
  output logic                         rdReqReady_o,
  output logic                         beatValid_o,
  output logic                         beatLast_o,
  output cacheGeomPkg::word_t          beatData_o,
  input  wire                          wbValid_i,
  input  wire memBusPkg::wbReq_t       wb_i,
  output logic                         wbReady_o,
  output int                           rdCount_o,
  output cacheGeomPkg::addr_t          lastRdAddr_o,
  output int                           wbCount_o,
  output cacheGeomPkg::addr_t          lastWbAddr_o,
  output cacheGeomPkg::line_t          lastWbLine_o
);

  // cycles from a seen request to its ready
  localparam int ReadLatency = 2;
  localparam int WbLatency   = 3;

  // sparse store keyed by word address
  cacheGeomPkg::word_t backing [cacheGeomPkg::addr_t];

  // unwritten words read as their address xor the key
  function automatic cacheGeomPkg::word_t readWord(input cacheGeomPkg::addr_t a);
    if (backing.exists(a)) return backing[a];
    return cacheGeomPkg::word_t'(a) ^ PatternKey;
  endfunction

  initial begin : refillLoop
    cacheGeomPkg::addr_t lineAddr;
    rdReqReady_o = 1'b0;
    beatValid_o  = 1'b0;
    beatLast_o   = 1'b0;
    beatData_o   = '0;
    rdCount_o    = 0;
    lastRdAddr_o = '0;
    forever begin
      @(posedge clk);
      #DriveDelay;
      if (rst_n && rdReqValid_i) begin
        lineAddr     = rdReqAddr_i;
        lastRdAddr_o = lineAddr;
        rdCount_o++;
        repeat (ReadLatency) @(posedge clk);
        #DriveDelay;
        rdReqReady_o = 1'b1;
        // beats start in the cycle after the request is taken
        for (int b = 0; b < cacheGeomPkg::BeatsPerLine; b++) begin
          @(posedge clk);
          #DriveDelay;
          rdReqReady_o = 1'b0;
          beatValid_o  = 1'b1;
          beatLast_o   = (b == cacheGeomPkg::BeatsPerLine - 1);
          beatData_o   = readWord(cacheGeomPkg::addr_t'(lineAddr + 8 * b));
        end
        @(posedge clk);
        #DriveDelay;
        beatValid_o = 1'b0;
        beatLast_o  = 1'b0;
        beatData_o  = '0;
      end
    end
  end

  initial begin : writeBackLoop
    wbReady_o    = 1'b0;
    wbCount_o    = 0;
    lastWbAddr_o = '0;
    lastWbLine_o = '0;
    forever begin
      @(posedge clk);
      #DriveDelay;
      if (rst_n && wbValid_i) begin
        repeat (WbLatency) @(posedge clk);
        #DriveDelay;
        wbReady_o    = 1'b1;
        lastWbAddr_o = wb_i.addr;
        lastWbLine_o = wb_i.line;
        wbCount_o++;
        for (int w = 0; w < cacheGeomPkg::BeatsPerLine; w++) begin
          backing[cacheGeomPkg::addr_t'(wb_i.addr + 8 * w)] =
            wb_i.line[w*cacheGeomPkg::WordBits +: cacheGeomPkg::WordBits];
        end
        @(posedge clk);
        #DriveDelay;
        wbReady_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/tbClock.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbClock #(
  parameter int PeriodNs = 100
) (
  output logic clk_o
);

  // free running, first rising edge half a period in
  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire
